//--- rtl/pool_pkg.sv
package pool_pkg;

    // Data word or byte address.
    typedef logic [31:0] word_t;

    // Image width, height or coordinate in words.
    typedef logic [7:0] dim_t;

    // Kernel size or stride where 0 reads as 1.
    typedef logic [1:0] ksize_t;

    typedef enum logic {
        POOL_MAX = 1'b0,  // Signed maximum.
        POOL_SUM = 1'b1   // Wrapping sum.
    } pool_mode_e;

    typedef enum logic [1:0] {
        OP_CONF = 2'd0,
        OP_DEST = 2'd1,
        OP_RUN  = 2'd2
    } cmd_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } ctrl_state_e;

    // CONF fields in rk.
    localparam int CONF_KSIZE_LSB  = 0;
    localparam int CONF_STRIDE_LSB = 2;
    localparam int CONF_MODE_BIT   = 4;
    localparam int CONF_WIDTH_LSB  = 8;
    localparam int CONF_HEIGHT_LSB = 16;

endpackage

//--- rtl/pool_cmd_ctrl.sv
module pool_cmd_ctrl import pool_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cmd_valid_i,
    input  cmd_op_e    cmd_op_i,
    input  word_t      cmd_rj_i,
    input  word_t      cmd_rk_i,
    input  logic       writer_done_i,
    output logic       rsp_valid_o,
    output logic       start_o,
    output ksize_t     ksize_o,
    output ksize_t     stride_o,
    output dim_t       width_o,
    output dim_t       height_o,
    output pool_mode_e mode_o,
    output word_t      src_base_o,
    output word_t      dst_base_o
);

    ctrl_state_e state_q;
    logic        cmd_acc;
    logic        conf_acc;
    logic        dest_acc;
    logic        run_acc;
    ksize_t      ksize_f;
    ksize_t      stride_f;

    assign cmd_acc  = cmd_valid_i && (state_q == ST_IDLE);  // Idle only.
    assign conf_acc = cmd_acc && (cmd_op_i == OP_CONF);
    assign dest_acc = cmd_acc && (cmd_op_i == OP_DEST);
    assign run_acc  = cmd_acc && (cmd_op_i == OP_RUN);

    assign ksize_f  = cmd_rk_i[CONF_KSIZE_LSB +: 2];
    assign stride_f = cmd_rk_i[CONF_STRIDE_LSB +: 2];

    always_ff @(posedge clk) begin
        if (conf_acc) begin
            ksize_o    <= (ksize_f == 2'd0) ? 2'd1 : ksize_f;
            stride_o   <= (stride_f == 2'd0) ? 2'd1 : stride_f;
            mode_o     <= pool_mode_e'(cmd_rk_i[CONF_MODE_BIT]);
            width_o    <= cmd_rk_i[CONF_WIDTH_LSB +: 8];
            height_o   <= cmd_rk_i[CONF_HEIGHT_LSB +: 8];
            src_base_o <= cmd_rj_i;
        end
        if (dest_acc) begin
            dst_base_o <= cmd_rj_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= conf_acc || dest_acc || (state_q == ST_DRAIN && writer_done_i);
            case (state_q)
                ST_IDLE: begin
                    if (run_acc) begin
                        state_q <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    state_q <= ST_DRAIN;  // Start goes out here.
                end
                ST_DRAIN: begin
                    if (writer_done_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign start_o = (state_q == ST_RUN);

endmodule

//--- rtl/window_reader.sv
module window_reader import pool_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_i,
    input  ksize_t     ksize_i,
    input  ksize_t     stride_i,
    input  dim_t       width_i,
    input  dim_t       height_i,
    input  pool_mode_e mode_i,
    input  word_t      src_base_i,
    input  logic       fifo_full_i,
    input  logic       rd_ack_i,
    input  word_t      rd_dat_i,
    output logic       rd_req_o,
    output word_t      rd_adr_o,
    output logic       push_o,
    output word_t      push_data_o,
    output logic       done_o
);

    dim_t       x_q;
    dim_t       y_q;
    ksize_t     i_q;
    ksize_t     j_q;
    logic       busy_q;
    logic       req_q;
    logic       push_q;
    logic       last_q;
    logic       done_q;
    word_t      acc_q;
    word_t      acc_nxt;
    logic       win_first;
    logic       i_last;
    logic       j_last;
    logic       fits;
    logic       fit_x;
    logic       fit_y;
    logic [9:0] nx_w;
    logic [9:0] ny_w;
    word_t      row;
    word_t      offs;

    assign win_first = (i_q == 2'd0) && (j_q == 2'd0);
    assign i_last    = (i_q == ksize_i - 2'd1);
    assign j_last    = (j_q == ksize_i - 2'd1);

    // Next origin and whether the window still fits.
    assign nx_w  = {2'b00, x_q} + 10'(stride_i);
    assign ny_w  = {2'b00, y_q} + 10'(stride_i);
    assign fit_x = (nx_w + 10'(ksize_i)) <= 10'(width_i);
    assign fit_y = (ny_w + 10'(ksize_i)) <= 10'(height_i);
    assign fits  = (10'(ksize_i) <= 10'(width_i)) && (10'(ksize_i) <= 10'(height_i));

    assign row      = word_t'(y_q) + word_t'(i_q);
    assign offs     = row * word_t'(width_i) + word_t'(x_q) + word_t'(j_q);
    assign rd_adr_o = src_base_i + (offs << 2);

    always_comb begin
        if (mode_i == POOL_MAX) begin
            acc_nxt = ($signed(rd_dat_i) > $signed(acc_q)) ? rd_dat_i : acc_q;
        end else begin
            acc_nxt = acc_q + rd_dat_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_q && rd_ack_i) begin
            acc_q <= win_first ? rd_dat_i : acc_nxt;  // First word seeds.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            req_q  <= 1'b0;
            push_q <= 1'b0;
            last_q <= 1'b0;
            done_q <= 1'b0;
            x_q    <= '0;
            y_q    <= '0;
            i_q    <= '0;
            j_q    <= '0;
        end else if (start_i) begin
            busy_q <= fits;
            done_q <= !fits;  // Image smaller than kernel.
            req_q  <= 1'b0;
            push_q <= 1'b0;
            last_q <= 1'b0;
            x_q    <= '0;
            y_q    <= '0;
            i_q    <= '0;
            j_q    <= '0;
        end else begin
            if (req_q && rd_ack_i) begin
                req_q <= 1'b0;
                if (!j_last) begin
                    j_q <= j_q + 2'd1;
                end else if (!i_last) begin
                    j_q <= '0;
                    i_q <= i_q + 2'd1;
                end else begin
                    j_q    <= '0;
                    i_q    <= '0;
                    push_q <= 1'b1;
                    if (fit_x) begin
                        x_q <= nx_w[7:0];
                    end else begin
                        x_q <= '0;
                        if (fit_y) begin
                            y_q <= ny_w[7:0];
                        end else begin
                            last_q <= 1'b1;
                        end
                    end
                end
            end else if (busy_q && !req_q && !push_q && (!win_first || !fifo_full_i)) begin
                req_q <= 1'b1;
            end
            if (push_q) begin
                push_q <= 1'b0;
                if (last_q) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    assign rd_req_o    = req_q;
    assign push_o      = push_q;
    assign push_data_o = acc_q;
    assign done_o      = done_q;

endmodule

//--- rtl/result_fifo.sv
module result_fifo import pool_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push_i,
    input  word_t push_data_i,
    input  logic  pop_i,
    output word_t head_data_o,
    output logic  full_o,
    output logic  empty_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    word_t         mem [FIFO_DEPTH];
    logic [AW-1:0] head_q;
    logic [AW-1:0] tail_q;
    logic          hwrap_q;
    logic          twrap_q;
    logic          do_push;
    logic          do_pop;
    logic          ptr_eq;

    assign ptr_eq  = (head_q == tail_q);
    assign full_o  = ptr_eq && (hwrap_q != twrap_q);
    assign empty_o = ptr_eq && (hwrap_q == twrap_q);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign head_data_o = mem[head_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            hwrap_q <= 1'b0;
            twrap_q <= 1'b0;
        end else begin
            if (do_push) begin
                tail_q <= tail_q + 1'b1;
                if (&tail_q) begin
                    twrap_q <= !twrap_q;  // Tail laps the buffer.
                end
            end
            if (do_pop) begin
                head_q <= head_q + 1'b1;
                if (&head_q) begin
                    hwrap_q <= !hwrap_q;
                end
            end
        end
    end

endmodule

//--- rtl/result_writer.sv
module result_writer import pool_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start_i,
    input  word_t dst_base_i,
    input  logic  empty_i,
    input  word_t head_data_i,
    input  logic  reader_done_i,
    input  logic  wr_ack_i,
    output logic  wr_req_o,
    output word_t wr_adr_o,
    output word_t wr_dat_o,
    output logic  pop_o,
    output logic  done_o
);

    logic  busy_q;
    logic  req_q;
    word_t adr_q;

    always_ff @(posedge clk) begin
        if (start_i) begin
            adr_q <= dst_base_i;
        end else if (req_q && wr_ack_i) begin
            adr_q <= adr_q + 32'd4;  // Next result word.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            req_q  <= 1'b0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            req_q  <= 1'b0;
        end else begin
            if (req_q && wr_ack_i) begin
                req_q <= 1'b0;
            end else if (busy_q && !req_q && !empty_i) begin
                req_q <= 1'b1;
            end
            if (done_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign wr_req_o = req_q;
    assign wr_adr_o = adr_q;
    assign wr_dat_o = head_data_i;  // Head is stable until pop.
    assign pop_o    = req_q && wr_ack_i;
    assign done_o   = busy_q && !req_q && empty_i && reader_done_i;

endmodule

//--- rtl/wb_arbiter.sv
module wb_arbiter import pool_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rd_req_i,
    input  word_t rd_adr_i,
    input  logic  wr_req_i,
    input  word_t wr_adr_i,
    input  word_t wr_dat_i,
    input  word_t wb_dat_i,
    input  logic  wb_ack_i,
    output logic  rd_ack_o,
    output word_t rd_dat_o,
    output logic  wr_ack_o,
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output logic  wb_we_o,
    output word_t wb_adr_o,
    output word_t wb_dat_o
);

    logic busy_q;
    logic sel_wr_q;
    logic sel_wr;
    logic active;

    // Reader wins when the bus is idle.
    assign sel_wr = busy_q ? sel_wr_q : !rd_req_i;
    assign active = busy_q || rd_req_i || wr_req_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q   <= 1'b0;
            sel_wr_q <= 1'b0;
        end else if (wb_ack_i) begin
            busy_q <= 1'b0;
        end else if (active) begin
            busy_q   <= 1'b1;  // Grant held until ack.
            sel_wr_q <= sel_wr;
        end
    end

    assign wb_cyc_o = active;
    assign wb_stb_o = active;
    assign wb_we_o  = active && sel_wr;
    assign wb_adr_o = sel_wr ? wr_adr_i : rd_adr_i;
    assign wb_dat_o = wr_dat_i;

    assign rd_ack_o = wb_ack_i && !sel_wr;
    assign wr_ack_o = wb_ack_i && sel_wr;
    assign rd_dat_o = wb_dat_i;

endmodule

//--- rtl/pool_accel.sv
module pool_accel import pool_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    cmd_valid_i,
    input  cmd_op_e cmd_op_i,
    input  word_t   cmd_rj_i,
    input  word_t   cmd_rk_i,
    output logic    rsp_valid_o,
    output logic    wb_cyc_o,
    output logic    wb_stb_o,
    output logic    wb_we_o,
    output word_t   wb_adr_o,
    output word_t   wb_dat_o,
    input  word_t   wb_dat_i,
    input  logic    wb_ack_i
);

    logic       start;
    ksize_t     ksize;
    ksize_t     stride;
    dim_t       width;
    dim_t       height;
    pool_mode_e mode;
    word_t      src_base;
    word_t      dst_base;
    logic       reader_done;
    logic       writer_done;
    logic       rd_req;
    word_t      rd_adr;
    logic       rd_ack;
    word_t      rd_dat;
    logic       wr_req;
    word_t      wr_adr;
    word_t      wr_dat;
    logic       wr_ack;
    logic       push;
    word_t      push_data;
    logic       pop;
    word_t      head_data;
    logic       fifo_full;
    logic       fifo_empty;

    pool_cmd_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_op_i      (cmd_op_i),
        .cmd_rj_i      (cmd_rj_i),
        .cmd_rk_i      (cmd_rk_i),
        .writer_done_i (writer_done),
        .rsp_valid_o   (rsp_valid_o),
        .start_o       (start),
        .ksize_o       (ksize),
        .stride_o      (stride),
        .width_o       (width),
        .height_o      (height),
        .mode_o        (mode),
        .src_base_o    (src_base),
        .dst_base_o    (dst_base)
    );

    window_reader u_reader (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start),
        .ksize_i     (ksize),
        .stride_i    (stride),
        .width_i     (width),
        .height_i    (height),
        .mode_i      (mode),
        .src_base_i  (src_base),
        .fifo_full_i (fifo_full),
        .rd_ack_i    (rd_ack),
        .rd_dat_i    (rd_dat),
        .rd_req_o    (rd_req),
        .rd_adr_o    (rd_adr),
        .push_o      (push),
        .push_data_o (push_data),
        .done_o      (reader_done)
    );

    result_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk         (clk),
        .rst         (rst),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_data_o (head_data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    result_writer u_writer (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start),
        .dst_base_i    (dst_base),
        .empty_i       (fifo_empty),
        .head_data_i   (head_data),
        .reader_done_i (reader_done),
        .wr_ack_i      (wr_ack),
        .wr_req_o      (wr_req),
        .wr_adr_o      (wr_adr),
        .wr_dat_o      (wr_dat),
        .pop_o         (pop),
        .done_o        (writer_done)
    );

    wb_arbiter u_arb (
        .clk      (clk),
        .rst      (rst),
        .rd_req_i (rd_req),
        .rd_adr_i (rd_adr),
        .wr_req_i (wr_req),
        .wr_adr_i (wr_adr),
        .wr_dat_i (wr_dat),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .rd_ack_o (rd_ack),
        .rd_dat_o (rd_dat),
        .wr_ack_o (wr_ack),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o)
    );

endmodule

//--- tb/wb_mem_model.sv
module wb_mem_model import pool_pkg::*; #(
    parameter int MEM_WORDS = 4096,
    parameter int LOG_DEPTH = 1024
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  max_wait_i,
    input  logic  wb_cyc_i,
    input  logic  wb_stb_i,
    input  logic  wb_we_i,
    input  word_t wb_adr_i,
    input  word_t wb_dat_i,
    output word_t wb_dat_o,
    output logic  wb_ack_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IW = $clog2(MEM_WORDS);

    word_t         mem [MEM_WORDS];
    word_t         wr_adr_log [LOG_DEPTH];
    word_t         wr_dat_log [LOG_DEPTH];
    int            wr_count;
    int            seed;
    int            rnd;
    logic [1:0]    wait_q;
    logic [IW-1:0] idx;

    assign idx = wb_adr_i[IW+1:2];  // Word index.

    initial begin
        wb_ack_o <= 1'b0;
        wb_dat_o <= '0;
        seed = 32'h7053;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = $random(seed);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
            wait_q   <= 2'd0;
            wr_count <= 0;
        end else if (wb_ack_o) begin
            wb_ack_o <= 1'b0;
            rnd = $random(seed);
            wait_q <= max_wait_i ? 2'd3 : rnd[1:0];  // Waits for the next transfer.
        end else if (wb_cyc_i && wb_stb_i) begin
            if (wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end else begin
                wb_ack_o <= 1'b1;
                if (wb_we_i) begin
                    mem[idx] = wb_dat_i;
                    wr_adr_log[wr_count] <= wb_adr_i;
                    wr_dat_log[wr_count] <= wb_dat_i;
                    wr_count <= wr_count + 1;
                end else begin
                    wb_dat_o <= mem[idx];
                end
            end
        end
    end

endmodule

//--- tb/pool_accel_tb.sv
module pool_accel_tb
    import pool_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_JOBS    = 6;
    localparam int MAX_RESULTS = 256;

    logic       clk;
    logic       rst;
    logic       cmd_valid;
    cmd_op_e    cmd_op;
    word_t      cmd_rj;
    word_t      cmd_rk;
    logic       rsp_valid;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    word_t      wb_adr;
    word_t      wb_dat_w;
    word_t      wb_dat_r;
    logic       wb_ack;
    logic       max_wait;

    int         seed;
    int         cycles = 0;
    int         limit = 1000;
    int         job_k [NUM_JOBS];
    int         job_s [NUM_JOBS];
    int         job_w [NUM_JOBS];
    int         job_h [NUM_JOBS];
    pool_mode_e job_mode [NUM_JOBS];
    word_t      job_src [NUM_JOBS];
    word_t      job_dst [NUM_JOBS];
    word_t      exp_dat [MAX_RESULTS];
    int         exp_n;

    pool_accel #(
        .FIFO_DEPTH (4)
    ) pool_accel_i (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_i (cmd_valid),
        .cmd_op_i    (cmd_op),
        .cmd_rj_i    (cmd_rj),
        .cmd_rk_i    (cmd_rk),
        .rsp_valid_o (rsp_valid),
        .wb_cyc_o    (wb_cyc),
        .wb_stb_o    (wb_stb),
        .wb_we_o     (wb_we),
        .wb_adr_o    (wb_adr),
        .wb_dat_o    (wb_dat_w),
        .wb_dat_i    (wb_dat_r),
        .wb_ack_i    (wb_ack)
    );

    wb_mem_model u_mem (
        .clk        (clk),
        .rst        (rst),
        .max_wait_i (max_wait),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_we_i    (wb_we),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_dat_w),
        .wb_dat_o   (wb_dat_r),
        .wb_ack_o   (wb_ack)
    );

    always #10 clk = ~clk;

    task abort_run();
        $display("Finished with errors");
        $fatal(1, "stopped at the first failure");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the DUT did not finish within %0d cycles", limit);
            abort_run();
        end
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual == expected) else begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic int size_or_one(input int v);
        return (v == 0) ? 1 : v;  // Zero reads as one.
    endfunction

    function automatic int window_count(input int k, input int s, input int n);
        return (n < k) ? 0 : (n - k) / s + 1;
    endfunction

    task automatic make_jobs();
        int rnd;
        job_k[0] = 2;
        job_s[0] = 2;
        job_w[0] = 6;
        job_h[0] = 4;
        job_mode[0] = POOL_MAX;
        job_k[1] = 3;
        job_s[1] = 1;
        job_w[1] = 7;
        job_h[1] = 5;
        job_mode[1] = POOL_SUM;
        for (int j = 2; j < NUM_JOBS; j++) begin
            rnd = $random(seed);
            job_k[j] = rnd & 3;
            job_s[j] = (rnd >> 2) & 3;
            job_w[j] = 3 + ((rnd >> 4) & 7);  // 3 to 10 words.
            job_h[j] = 3 + ((rnd >> 12) & 7);
            job_mode[j] = rnd[8] ? POOL_SUM : POOL_MAX;
        end
        for (int j = 0; j < NUM_JOBS; j++) begin
            job_src[j] = word_t'(j * 32'h400);
            job_dst[j] = 32'h2000 + word_t'(j * 32'h400);
        end
    endtask

    task automatic compute_expected(input int job);
        int    k;
        int    s;
        int    base;
        word_t acc;
        word_t v;
        k = size_or_one(job_k[job]);
        s = size_or_one(job_s[job]);
        base = int'(job_src[job] >> 2);
        exp_n = 0;
        for (int y = 0; y + k <= job_h[job]; y += s) begin
            for (int x = 0; x + k <= job_w[job]; x += s) begin
                acc = '0;
                for (int i = 0; i < k; i++) begin
                    for (int jj = 0; jj < k; jj++) begin
                        v = u_mem.mem[base + (y + i) * job_w[job] + x + jj];
                        if (i == 0 && jj == 0) begin
                            acc = v;
                        end else if (job_mode[job] == POOL_MAX) begin
                            acc = ($signed(v) > $signed(acc)) ? v : acc;
                        end else begin
                            acc = acc + v;  // Wraps at 32 bits.
                        end
                    end
                end
                exp_dat[exp_n] = acc;
                exp_n++;
            end
        end
    endtask

    task automatic send_cmd(input cmd_op_e op, input word_t rj, input word_t rk);
        @(negedge clk);
        check_value("response low before command", 32'd0, word_t'(rsp_valid));
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_rj    = rj;
        cmd_rk    = rk;
        @(negedge clk);
        cmd_valid = 1'b0;
        if (op != OP_RUN) begin
            check_value("response one cycle after command", 32'd1, word_t'(rsp_valid));
            @(negedge clk);
            check_value("response lasts one cycle", 32'd0, word_t'(rsp_valid));
        end
    endtask

    task automatic run_job(input int job, input string name);
        word_t rk;
        word_t adr;
        int    first;
        compute_expected(job);
        rk = (word_t'(job_h[job]) << CONF_HEIGHT_LSB)
           | (word_t'(job_w[job]) << CONF_WIDTH_LSB)
           | (word_t'(job_mode[job]) << CONF_MODE_BIT)
           | (word_t'(job_s[job]) << CONF_STRIDE_LSB)
           | word_t'(job_k[job]);
        send_cmd(OP_CONF, job_src[job], rk);
        send_cmd(OP_DEST, job_dst[job], 32'd0);
        first = u_mem.wr_count;
        send_cmd(OP_RUN, 32'd0, 32'd0);
        while (rsp_valid !== 1'b1) begin
            @(negedge clk);
        end
        check_value({name, " write count"}, word_t'(exp_n), word_t'(u_mem.wr_count - first));
        for (int r = 0; r < exp_n; r++) begin
            adr = u_mem.wr_adr_log[first + r];
            check_value($sformatf("%s address %0d", name, r), job_dst[job] + word_t'(4 * r), adr);
            check_value($sformatf("%s result %0d", name, r), exp_dat[r],
                        u_mem.wr_dat_log[first + r]);
        end
        @(negedge clk);
        check_value({name, " run response lasts one cycle"}, 32'd0, word_t'(rsp_valid));
    endtask

    initial begin
        int k;
        int s;
        int nw;
        int work;
        clk       = 1'b0;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = OP_CONF;
        cmd_rj    = '0;
        cmd_rk    = '0;
        max_wait  = 1'b0;
        seed      = 32'h7053;
        make_jobs();
        work = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            k = size_or_one(job_k[j]);
            s = size_or_one(job_s[j]);
            nw = window_count(k, s, job_w[j]) * window_count(k, s, job_h[j]);
            work += nw * k * k + nw;
        end
        limit = 8 * work + 1000;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("bus idle after reset", 32'd0, word_t'(wb_cyc));
            check_value("strobe low after reset", 32'd0, word_t'(wb_stb));
            check_value("write enable low after reset", 32'd0, word_t'(wb_we));
            check_value("response low after reset", 32'd0, word_t'(rsp_valid));
        end
        run_job(0, "max_k2_s2");
        run_job(1, "sum_k3_s1");
        @(negedge clk);
        max_wait = 1'b1;  // Slowest slave from here on.
        for (int j = 2; j < NUM_JOBS; j++) begin
            run_job(j, $sformatf("random_%0d", j));
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- src.f
rtl/pool_pkg.sv
rtl/pool_cmd_ctrl.sv
rtl/window_reader.sv
rtl/result_fifo.sv
rtl/result_writer.sv
rtl/wb_arbiter.sv
rtl/pool_accel.sv
tb/wb_mem_model.sv
tb/pool_accel_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert -Wno-fatal --top-module pool_accel_tb -f src.f -o pool_accel_sim; then
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/pool_accel_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "Pass message not found in $LOG."
exit 1
